// File: common/of_macros.svh
`ifndef OF_MACROS_SVH
`define OF_MACROS_SVH

// Datapath width of the core
`define OF_XLEN 32

// Register index width, matches the rd/rs fields of the encoding
`define OF_REG_AW 5

// Architectural register count
`define OF_NREGS 32

`endif

// File: common/isa_pkg.sv
`include "of_macros.svh"

package isa_pkg;

   // Opcode class bits
   localparam int unsigned OPC_IMM_BIT  = 5; // Set for immediate form
   localparam int unsigned OPC_SEXT_BIT = 4; // Immediate form only, set for sign extension

   localparam int unsigned IMM_W   = 16;
   localparam int unsigned FUNCT_W = 11;

   typedef logic [5:0]             opcode_t;
   typedef logic [`OF_REG_AW-1:0]  reg_idx_t;
   typedef logic [FUNCT_W-1:0]     funct_t;
   typedef logic [IMM_W-1:0]       imm_t;

   // Register form, two sources
   typedef struct packed {
      opcode_t  opcode; // [31:26]
      reg_idx_t rd;     // [25:21]
      reg_idx_t rs1;    // [20:16]
      reg_idx_t rs2;    // [15:11]
      funct_t   funct;  // [10:0]
   } insn_r_t;

   // Immediate form, one source plus 16-bit constant
   typedef struct packed {
      opcode_t  opcode; // [31:26]
      reg_idx_t rd;     // [25:21]
      reg_idx_t rs1;    // [20:16]
      imm_t     imm;    // [15:0]
   } insn_i_t;

   // Same 32-bit word seen through either format
   typedef union packed {
      insn_r_t r;
      insn_i_t i;
   } insn_u;

endpackage

// File: common/of_pkg.sv
`include "of_macros.svh"

package of_pkg;

   typedef logic [`OF_XLEN-1:0] data_t;

   // Writeback from a later stage
   typedef struct packed {
      logic             we;   // Write strobe
      isa_pkg::reg_idx_t addr;
      data_t            data;
   } wb_req_t;

   // Decoded instruction, both formats flattened
   typedef struct packed {
      logic              is_imm;     // Immediate form
      logic              imm_signed; // Sign-extend imm
      isa_pkg::opcode_t  opcode;
      isa_pkg::reg_idx_t rd;
      isa_pkg::reg_idx_t rs1;
      isa_pkg::reg_idx_t rs2;        // Don't care in immediate form
      isa_pkg::funct_t   funct;      // Don't care in immediate form
      isa_pkg::imm_t     imm;        // Don't care in register form
   } dec_fields_t;

   // Stage output towards execute
   typedef struct packed {
      logic              valid;
      isa_pkg::opcode_t  opcode;
      isa_pkg::reg_idx_t rd;
      isa_pkg::funct_t   funct;
      data_t             opa;
      data_t             opb;
   } of_result_t;

endpackage

// File: rtl/dpram_sclk.sv
`timescale 1ns/1ps

module dpram_sclk #(
   parameter int unsigned ADDR_WIDTH    = 5,
   parameter int unsigned DATA_WIDTH    = 32,
   parameter bit          ENABLE_BYPASS = 1'b1
) (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  logic [ADDR_WIDTH-1:0] raddr_i,
   input  logic                  re_i,
   input  logic [ADDR_WIDTH-1:0] waddr_i,
   input  logic                  we_i,
   input  logic [DATA_WIDTH-1:0] din_i,
   output logic [DATA_WIDTH-1:0] dout_o,
   output logic                  dout_valid_o
);

   logic [DATA_WIDTH-1:0] mem_q [(1<<ADDR_WIDTH)]; // Storage array
   logic [DATA_WIDTH-1:0] rdata_q;                 // Registered array word
   logic                  re_q;                    // Read issued last cycle

   // Array write and synchronous read, old data on collision
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem_q[waddr_i] <= din_i;
      end
      if (re_i) begin
         rdata_q <= mem_q[raddr_i];
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         re_q <= 1'b0;
      end else begin
         re_q <= re_i; // Valid trails enable by one cycle
      end
   end

   assign dout_valid_o = re_q;

   generate
      if (ENABLE_BYPASS) begin : g_bypass
         logic                  hit_w;    // Same-address write and read
         logic                  bypass_q; // Last read collided with a write
         logic [DATA_WIDTH-1:0] wdata_q;  // Write data of that collision

         assign hit_w = re_i && we_i && (waddr_i == raddr_i);

         always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
               bypass_q <= 1'b0;
            end else if (re_i) begin
               bypass_q <= hit_w; // Only a new read changes the source
            end
         end

         always_ff @(posedge clk_i) begin
            if (hit_w) begin
               wdata_q <= din_i; // Captured only on a collision
            end
         end

         assign dout_o = bypass_q ? wdata_q : rdata_q; // New data wins
      end else begin : g_no_bypass
         assign dout_o = rdata_q; // Collision returns old word
      end
   endgenerate

   // No read issued means no valid data the next cycle
   a_no_spurious_valid : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      !re_i |=> !dout_valid_o
   ) else $error("dpram_sclk: dout_valid_o without a preceding read");

endmodule

// File: regfile/regfile_2r1w.sv
`timescale 1ns/1ps
`include "of_macros.svh"

module regfile_2r1w (
   input  logic              clk_i,
   input  logic              rst_n_i,
   input  isa_pkg::reg_idx_t raddr_a_i,
   input  isa_pkg::reg_idx_t raddr_b_i,
   input  logic              re_a_i,
   input  logic              re_b_i,
   input  of_pkg::wb_req_t   wb_i,
   output of_pkg::data_t     rdata_a_o,
   output of_pkg::data_t     rdata_b_o
);

   localparam int unsigned AW = $clog2(`OF_NREGS); // One word per register

   logic valid_a_w; // Bank A read data valid
   logic valid_b_w; // Bank B read data valid

   // Bank A serves read port A, gets every write
   dpram_sclk #(
      .ADDR_WIDTH    (AW),
      .DATA_WIDTH    (`OF_XLEN),
      .ENABLE_BYPASS (1'b1)
   ) u_bank_a (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .raddr_i      (raddr_a_i),
      .re_i         (re_a_i),
      .waddr_i      (wb_i.addr),
      .we_i         (wb_i.we),
      .din_i        (wb_i.data),
      .dout_o       (rdata_a_o),
      .dout_valid_o (valid_a_w)
   );

   // Bank B mirrors A, serves read port B
   dpram_sclk #(
      .ADDR_WIDTH    (AW),
      .DATA_WIDTH    (`OF_XLEN),
      .ENABLE_BYPASS (1'b1)
   ) u_bank_b (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .raddr_i      (raddr_b_i),
      .re_i         (re_b_i),
      .waddr_i      (wb_i.addr),
      .we_i         (wb_i.we),
      .din_i        (wb_i.data),
      .dout_o       (rdata_b_o),
      .dout_valid_o (valid_b_w)
   );

   // Both banks answer exactly the reads issued a cycle earlier
   a_bank_valid_match : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $past(rst_n_i) |-> ({valid_a_w, valid_b_w} == $past({re_a_i, re_b_i}))
   ) else $error("regfile_2r1w: bank valid does not follow read enables");

endmodule

// File: rtl/insn_decode.sv
`timescale 1ns/1ps

module insn_decode (
   input  isa_pkg::insn_u      insn_i,
   output of_pkg::dec_fields_t fields_o
);

   import isa_pkg::*;

   opcode_t opc_w; // Opcode sits at the same place in both views
   logic    imm_form_w;

   assign opc_w      = insn_i.i.opcode;
   assign imm_form_w = opc_w[OPC_IMM_BIT];

   always_comb begin
      // Class bits
      fields_o.is_imm     = imm_form_w;
      fields_o.imm_signed = imm_form_w & opc_w[OPC_SEXT_BIT]; // Bit 4 meaningless in R form

      // Common fields
      fields_o.opcode = opc_w;
      fields_o.rd     = insn_i.i.rd;
      fields_o.rs1    = insn_i.i.rs1;

      // Register view
      fields_o.rs2   = insn_i.r.rs2;
      fields_o.funct = insn_i.r.funct;

      // Immediate view, same low bits as rs2/funct
      fields_o.imm = insn_i.i.imm;
   end

endmodule

// File: rtl/of_ctrl.sv
`timescale 1ns/1ps

module of_ctrl (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                insn_valid_i,
   input  of_pkg::dec_fields_t fields_i,
   output logic                re_a_o,
   output logic                re_b_o,
   output of_pkg::dec_fields_t held_o,
   output logic                valid_o
);

   import isa_pkg::*;
   import of_pkg::*;

   dec_fields_t held_q;  // Fields of the instruction in flight
   logic        valid_q; // Operands due this cycle

   // Port A read on every instruction
   assign re_a_o = insn_valid_i;
   // Port B idle for immediate form, saves a RAM access
   assign re_b_o = insn_valid_i & ~fields_i.is_imm;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= insn_valid_i; // One cycle, no stall
      end
   end

   always_ff @(posedge clk_i) begin
      if (insn_valid_i) begin
         held_q <= fields_i; // Hold on idle cycles
      end
   end

   assign held_o  = held_q;
   assign valid_o = valid_q;

   // Raw opcode class must never open port B
   a_no_port_b_on_imm : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      fields_i.opcode[OPC_IMM_BIT] |-> !re_b_o
   ) else $error("of_ctrl: port B read issued for immediate form");

endmodule

// File: rtl/operand_select.sv
`timescale 1ns/1ps
`include "of_macros.svh"

module operand_select (
   input  of_pkg::dec_fields_t held_i,
   input  logic                valid_i,
   input  of_pkg::data_t       rdata_a_i,
   input  of_pkg::data_t       rdata_b_i,
   output of_pkg::of_result_t  result_o
);

   import isa_pkg::*;
   import of_pkg::*;

   data_t imm_ext_w; // Immediate widened to XLEN
   data_t opa_w;
   data_t opb_w;
   logic  ext_bit_w; // Fill bit for the upper half

   assign ext_bit_w = held_i.imm_signed & held_i.imm[IMM_W-1];
   assign imm_ext_w = {{(`OF_XLEN-IMM_W){ext_bit_w}}, held_i.imm};

   // r0 hardwired to zero, RAM content ignored
   assign opa_w = (held_i.rs1 == '0) ? '0 : rdata_a_i;

   always_comb begin
      if (held_i.is_imm) begin
         opb_w = imm_ext_w; // Port B not read
      end else if (held_i.rs2 == '0) begin
         opb_w = '0;
      end else begin
         opb_w = rdata_b_i;
      end
   end

   always_comb begin
      result_o.valid  = valid_i;
      result_o.opcode = held_i.opcode;
      result_o.rd     = held_i.rd;
      result_o.funct  = held_i.funct;
      result_o.opa    = opa_w;
      result_o.opb    = opb_w;
   end

endmodule

// File: rtl/operand_fetch_top.sv
`timescale 1ns/1ps

module operand_fetch_top (
   input  logic               clk_i,
   input  logic               rst_n_i,
   input  isa_pkg::insn_u     insn_i,
   input  logic               insn_valid_i,
   input  of_pkg::wb_req_t    wb_i,
   output of_pkg::of_result_t result_o
);

   import of_pkg::*;

   dec_fields_t fields_w;  // Decode output, this cycle
   dec_fields_t held_w;    // Registered fields, next cycle
   logic        re_a_w;
   logic        re_b_w;
   logic        valid_w;
   data_t       rdata_a_w;
   data_t       rdata_b_w;

   insn_decode u_decode (
      .insn_i   (insn_i),
      .fields_o (fields_w)
   );

   of_ctrl u_ctrl (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .insn_valid_i (insn_valid_i),
      .fields_i     (fields_w),
      .re_a_o       (re_a_w),
      .re_b_o       (re_b_w),
      .held_o       (held_w),
      .valid_o      (valid_w)
   );

   regfile_2r1w u_regfile (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .raddr_a_i (fields_w.rs1),
      .raddr_b_i (fields_w.rs2),
      .re_a_i    (re_a_w),
      .re_b_i    (re_b_w),
      .wb_i      (wb_i),
      .rdata_a_o (rdata_a_w),
      .rdata_b_o (rdata_b_w)
   );

   operand_select u_select (
      .held_i    (held_w),
      .valid_i   (valid_w),
      .rdata_a_i (rdata_a_w),
      .rdata_b_i (rdata_b_w),
      .result_o  (result_o)
   );

endmodule

// File: dv/tb_operand_fetch.sv
`timescale 1ns/1ps
`include "of_macros.svh"

module tb_operand_fetch;

   import isa_pkg::*;
   import of_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int N_INIT     = `OF_NREGS; // One write per register
   localparam int N_REG      = 24;
   localparam int N_ZERO     = 5;
   localparam int N_BYP      = 16;
   localparam int N_IMM      = 24;
   localparam int N_RAND     = 400;
   localparam int N_DRAIN    = 3;         // Last result checked, then counted
   localparam int N_TESTS    = 6;
   localparam int TOTAL_CYC  = 2 + N_INIT + N_REG + N_ZERO + N_BYP + N_IMM + N_RAND
                               + N_TESTS * N_DRAIN + 100; // Reset, tests, margin

   logic        clk = 1'b0;
   logic        rst_n;
   insn_u       insn;
   logic        insn_valid;
   wb_req_t     wb;
   of_result_t  result;

   of_result_t  exp_r;             // Expected result, driven with the strobe
   of_result_t  exp_q;             // Same, one edge later, lines up with result
   data_t       model [`OF_NREGS]; // Reference register file
   logic [31:0] lfsr;
   int          err_cnt = 0;       // Value errors over the whole run
   int          err_base;
   int          test_id;
   int          n_pass;
   int          n_fail;

   operand_fetch_top u_operand_fetch_top (
      .clk_i        (clk),
      .rst_n_i      (rst_n),
      .insn_i       (insn),
      .insn_valid_i (insn_valid),
      .wb_i         (wb),
      .result_o     (result)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) exp_q <= exp_r; // One-cycle stage latency

   task automatic flag_error(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      err_cnt++;
   endtask

   // Galois LFSR x^32+x^22+x^2+x+1, one step per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      val = '0;
      for (int k = 0; k < n; k++) begin
         val  = {val[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      end
      return val;
   endfunction

   function automatic logic [31:0] make_reg_insn(input logic [4:0] opc, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                                 input logic [10:0] funct);
      return {1'b0, opc, rd, rs1, rs2, funct}; // Bit 31 clear, register form
   endfunction

   function automatic logic [31:0] make_imm_insn(input logic sext, input logic [3:0] opc,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [15:0] imm);
      return {1'b1, sext, opc, rd, rs1, imm};
   endfunction

   function automatic logic [31:0] rand_insn(input logic imm_form);
      logic [4:0] rd;
      logic [4:0] rs1;
      rd  = 5'(rand_bits(5));
      rs1 = 5'(rand_bits(5));
      if (imm_form) begin
         return make_imm_insn(1'(rand_bits(1)), 4'(rand_bits(4)), rd, rs1, 16'(rand_bits(16)));
      end
      return make_reg_insn(5'(rand_bits(5)), rd, rs1, 5'(rand_bits(5)), 11'(rand_bits(11)));
   endfunction

   // Model the cycle, then drive it on the next rising edge
   task automatic drive_cycle(input logic vld, input logic [31:0] word, input logic we,
                              input logic [4:0] waddr, input data_t wdata);
      of_result_t  exp;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [15:0] imm;
      rs1 = word[20:16];
      rs2 = word[15:11];
      imm = word[15:0];
      if (we) begin
         model[waddr] = wdata; // Same-edge read returns the new word
      end
      exp.valid  = vld;
      exp.opcode = word[31:26];
      exp.rd     = word[25:21];
      exp.funct  = word[10:0];
      exp.opa    = (rs1 == 5'd0) ? '0 : model[rs1];
      if (word[31]) begin
         exp.opb = word[30] ? {{16{imm[15]}}, imm} : {16'h0, imm}; // Sign or zero fill
      end else begin
         exp.opb = (rs2 == 5'd0) ? '0 : model[rs2];
      end
      @(posedge clk);
      insn_valid <= vld;
      insn       <= word;
      wb.we      <= we;
      wb.addr    <= waddr;
      wb.data    <= wdata;
      exp_r      <= exp;
   endtask

   task automatic start_test();
      err_base = err_cnt;
      test_id++;
   endtask

   task automatic finish_test(input string name);
      int errs;
      repeat (N_DRAIN) drive_cycle(1'b0, 32'h0, 1'b0, 5'd0, '0); // Let last checks fire
      errs = err_cnt - err_base;
      if (errs == 0) begin
         n_pass++;
         $display("test %0d %s: ok", test_id, name);
      end else begin
         n_fail++;
         $display("test %0d %s: %0d errors", test_id, name, errs);
      end
   endtask

   a_reset_valid_low : assert property (
      @(posedge clk) (!rst_n ##1 !rst_n) |-> !result.valid
   ) else flag_error("result valid high during reset");

   a_valid_after_strobe : assert property (
      @(posedge clk) disable iff (!rst_n)
      insn_valid |=> result.valid
   ) else flag_error("result valid missing one cycle after strobe");

   a_no_valid_idle : assert property (
      @(posedge clk) disable iff (!rst_n)
      !insn_valid |=> !result.valid
   ) else flag_error("result valid high after idle cycle");

   a_opa : assert property (
      @(posedge clk) disable iff (!rst_n)
      insn_valid |=> (result.opa == exp_q.opa)
   ) else flag_error($sformatf("opa got %h expected %h",
                               $sampled(result.opa), $sampled(exp_q.opa)));

   a_opb : assert property (
      @(posedge clk) disable iff (!rst_n)
      insn_valid |=> (result.opb == exp_q.opb)
   ) else flag_error($sformatf("opb got %h expected %h",
                               $sampled(result.opb), $sampled(exp_q.opb)));

   // Opcode, rd and funct passed through together
   a_fields : assert property (
      @(posedge clk) disable iff (!rst_n)
      insn_valid |=> ({result.opcode, result.rd, result.funct}
                      == {exp_q.opcode, exp_q.rd, exp_q.funct})
   ) else flag_error($sformatf("opcode/rd/funct got %h expected %h",
                               $sampled({result.opcode, result.rd, result.funct}),
                               $sampled({exp_q.opcode, exp_q.rd, exp_q.funct})));

   initial begin
      #(TOTAL_CYC * CLK_PERIOD);
      $display("Timeout: run did not finish within %0d cycles", TOTAL_CYC);
      $display("Some tests failed");
      $finish;
   end

   initial begin
      logic        vld;
      logic        we;
      logic [31:0] word;
      logic [4:0]  k;
      logic [4:0]  waddr;
      rst_n      = 1'b0;
      insn       = '0;
      insn_valid = 1'b0;
      wb         = '0;
      exp_r      = '0;
      lfsr       = 32'h4626;
      test_id    = 0;
      n_pass     = 0;
      n_fail     = 0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;

      start_test(); // Fill every register, no strobes
      for (int r = 0; r < N_INIT; r++) begin
         drive_cycle(1'b0, 32'h0, 1'b1, 5'(r), rand_bits(32));
      end
      finish_test("reset and idle");

      start_test();
      for (int i = 0; i < N_REG; i++) begin
         drive_cycle(1'b1, rand_insn(1'b0), 1'b0, 5'd0, '0); // Back to back
      end
      finish_test("register form");

      start_test();
      drive_cycle(1'b0, 32'h0, 1'b1, 5'd0, 32'hffff_ffff);
      drive_cycle(1'b1, make_reg_insn(5'd1, 5'd2, 5'd0, 5'd0, 11'h7ff), 1'b0, 5'd0, '0);
      drive_cycle(1'b1, make_reg_insn(5'd3, 5'd4, 5'd0, 5'd7, 11'h0), 1'b1, 5'd0, 32'h1234_5678);
      drive_cycle(1'b1, make_imm_insn(1'b1, 4'h2, 5'd5, 5'd0, 16'h8001), 1'b0, 5'd0, '0);
      drive_cycle(1'b1, make_reg_insn(5'd6, 5'd0, 5'd9, 5'd0, 11'h155), 1'b0, 5'd0, '0);
      finish_test("register zero");

      start_test();
      for (int i = 0; i < N_BYP; i++) begin
         k = 5'(rand_bits(5));
         if (k == 5'd0) begin
            k = 5'd1;
         end
         if (i[0]) begin
            word = make_imm_insn(1'(rand_bits(1)), 4'(rand_bits(4)), 5'(rand_bits(5)), k,
                                 16'(rand_bits(16)));
         end else begin
            word = make_reg_insn(5'(rand_bits(5)), 5'(rand_bits(5)), k, k, 11'(rand_bits(11)));
         end
         drive_cycle(1'b1, word, 1'b1, k, rand_bits(32)); // Write and read same register
      end
      finish_test("write bypass");

      start_test();
      for (int i = 0; i < N_IMM; i++) begin
         word = make_imm_insn(i[0], 4'(rand_bits(4)), 5'(rand_bits(5)), 5'(rand_bits(5)),
                              {i[1], 15'(rand_bits(15))}); // All sext/msb combinations
         drive_cycle(1'b1, word, 1'b0, 5'd0, '0);
      end
      finish_test("immediate form");

      start_test();
      for (int i = 0; i < N_RAND; i++) begin
         vld   = 1'(rand_bits(1));
         word  = rand_insn(1'(rand_bits(1)));
         we    = 1'(rand_bits(1));
         waddr = rand_bits(1) ? word[20:16] : 5'(rand_bits(5)); // Aim at rs1 half the time
         drive_cycle(vld, word, we, waddr, rand_bits(32));
      end
      finish_test("random traffic");

      $display("tests %0d, passed %0d, failed %0d, value errors %0d",
               test_id, n_pass, n_fail, err_cnt);
      if (n_fail == 0 && err_cnt == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// File: project.f
+incdir+common
common/isa_pkg.sv
common/of_pkg.sv
rtl/dpram_sclk.sv
regfile/regfile_2r1w.sv
rtl/insn_decode.sv
rtl/of_ctrl.sv
rtl/operand_select.sv
rtl/operand_fetch_top.sv
dv/tb_operand_fetch.sv

// File: Bender.yml
package:
  name: operand_fetch

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/isa_pkg.sv
      - common/of_pkg.sv
      - rtl/dpram_sclk.sv
      - regfile/regfile_2r1w.sv
      - rtl/insn_decode.sv
      - rtl/of_ctrl.sv
      - rtl/operand_select.sv
      - rtl/operand_fetch_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/tb_operand_fetch.sv
